//--- rtl/exc_pkg.sv
package exc_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    ////////////////////////////////////////////////////////////////////
    // exception codes
    ////////////////////////////////////////////////////////////////////

    localparam ecode_t ECODE_ADEF = 6'h08;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0B;
    localparam ecode_t ECODE_BRK  = 6'h0C;
    localparam ecode_t ECODE_INE  = 6'h0D;
    // tlb refill goes to its own entry
    localparam ecode_t ECODE_TLBR = 6'h3F;

    ////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////

    // exception state carried with an instruction down the pipe
    typedef struct packed {
        logic        has_exception;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] maddr;
        logic        ertn;
    } exc_info_t;

    // what writeback hands to the csr unit on commit
    typedef struct packed {
        logic        exception;
        logic        ertn;
        logic        tlbr;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] pc;
        logic [31:0] maddr;
    } commit_exc_t;

endpackage

//--- rtl/wb_types_pkg.sv
package wb_types_pkg;

    import exc_pkg::*;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // one-hot load kind with the upper bits reserved
    typedef logic [7:0] mem_op_t;

    localparam int MEM_OP_LB  = 0;
    localparam int MEM_OP_LH  = 1;
    localparam int MEM_OP_LW  = 2;
    localparam int MEM_OP_LBU = 3;
    localparam int MEM_OP_LHU = 4;

    ////////////////////////////////////////////////////////////////////
    // bundle from the memory stage
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      inst_valid;
        word_t     pc;
        word_t     alu_result;
        word_t     mem_rdata;
        word_t     csr_result;
        word_t     mul_result;
        word_t     div_result;
        mem_op_t   mem_op;
        logic      res_from_mem;
        logic      res_from_csr;
        logic      res_from_mul;
        logic      res_from_div;
        logic      rdcntid;
        logic      gr_we;
        reg_idx_t  dest;
        exc_info_t exc;
    } wb_bundle_t;

endpackage

//--- rtl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage
    import exc_pkg::*;
    import wb_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        in_valid,
    output logic        in_ready,
    input  wb_bundle_t  in_bundle,

    input  word_t       csr_tid,
    output word_t       result_bypass,

    output logic        rf_we,
    output reg_idx_t    rf_waddr,
    output word_t       rf_wdata,

    output commit_exc_t commit,
    output logic        flush,

    output word_t       debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output reg_idx_t    debug_wb_rf_wnum,
    output word_t       debug_wb_rf_wdata
);

    wb_bundle_t slot;
    logic       slot_full;
    logic       run;
    logic       accept;
    logic       slot_flush;

    logic [1:0] addr_lo;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    word_t      mem_result;
    word_t      final_result;

    ////////////////////////////////////////////////////////////////////
    // input slot
    ////////////////////////////////////////////////////////////////////

    // writeback never stalls and only a flushing instruction blocks the input
    assign slot_flush = slot_full & (slot.exc.has_exception | slot.exc.ertn);
    assign in_ready   = run & ~slot_flush;
    assign accept     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            run       <= 1'b0;
            slot_full <= 1'b0;
        end else begin
            run       <= 1'b1;
            slot_full <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot <= in_bundle;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // load data extraction
    ////////////////////////////////////////////////////////////////////

    assign addr_lo = slot.alu_result[1:0];

    always_comb begin
        case (addr_lo)
            2'b00:   load_byte = slot.mem_rdata[7:0];
            2'b01:   load_byte = slot.mem_rdata[15:8];
            2'b10:   load_byte = slot.mem_rdata[23:16];
            default: load_byte = slot.mem_rdata[31:24];
        endcase
        load_half = addr_lo[1] ? slot.mem_rdata[31:16] : slot.mem_rdata[15:0];
    end

    always_comb begin
        mem_result = '0;
        if (slot.mem_op[MEM_OP_LB]) begin
            mem_result = {{24{load_byte[7]}}, load_byte};
        end else if (slot.mem_op[MEM_OP_LBU]) begin
            mem_result = {24'b0, load_byte};
        end else if (slot.mem_op[MEM_OP_LH]) begin
            mem_result = {{16{load_half[15]}}, load_half};
        end else if (slot.mem_op[MEM_OP_LHU]) begin
            mem_result = {16'b0, load_half};
        end else if (slot.mem_op[MEM_OP_LW]) begin
            mem_result = slot.mem_rdata;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // result select and register write
    ////////////////////////////////////////////////////////////////////

    // bypass path skips mul/div and tid
    assign result_bypass = slot.res_from_mem ? mem_result :
                           slot.res_from_csr ? slot.csr_result :
                           slot.alu_result;

    assign final_result = slot.rdcntid      ? csr_tid         :
                          slot.res_from_mem ? mem_result      :
                          slot.res_from_csr ? slot.csr_result :
                          slot.res_from_mul ? slot.mul_result :
                          slot.res_from_div ? slot.div_result :
                          slot.alu_result;

    assign rf_we    = slot_full & slot.gr_we & slot.inst_valid & ~slot.exc.has_exception;
    assign rf_waddr = slot.dest;
    assign rf_wdata = final_result;

    assign debug_wb_pc       = slot.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = slot.dest;
    assign debug_wb_rf_wdata = final_result;

    ////////////////////////////////////////////////////////////////////
    // exception submission
    ////////////////////////////////////////////////////////////////////

    assign flush = slot_flush;

    assign commit.exception = slot_full & slot.exc.has_exception;
    assign commit.ertn      = slot_full & slot.exc.ertn;
    assign commit.tlbr      = slot_full & slot.exc.has_exception
                              & (slot.exc.ecode == ECODE_TLBR);
    assign commit.ecode     = slot.exc.ecode;
    assign commit.esubcode  = slot.exc.esubcode;
    assign commit.pc        = slot.pc;
    assign commit.maddr     = slot.exc.maddr;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile
    import wb_types_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,

    input  reg_idx_t raddr1,
    output word_t    rdata1,
    input  reg_idx_t raddr2,
    output word_t    rdata2
);

    word_t regs [32];

    ////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////

    // no forwarding of a same-edge write
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- rtl/csr_exc_unit.sv
`timescale 1ns/1ps

module csr_exc_unit
    import exc_pkg::*;
    import wb_types_pkg::*;
#(
    parameter word_t EENTRY    = 32'h1C00_8000,
    parameter word_t TLBRENTRY = 32'h1C00_F000,
    parameter word_t CORE_ID   = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,

    input  commit_exc_t commit,
    input  logic        flush,

    output word_t       csr_tid,
    output word_t       flush_pc,

    output word_t       crmd,
    output word_t       prmd,
    output word_t       era,
    output word_t       estat,
    output word_t       badv
);

    logic       exc_take;
    logic       ertn_take;
    logic       badv_take;

    logic [1:0] crmd_plv;
    logic       crmd_ie;
    logic [1:0] prmd_pplv;
    logic       prmd_pie;
    word_t      era_q;
    ecode_t     estat_ecode;
    esubcode_t  estat_esubcode;
    word_t      badv_q;

    // exception wins over ertn if both show up
    assign exc_take  = flush & commit.exception;
    assign ertn_take = flush & commit.ertn & ~commit.exception;

    assign badv_take = exc_take & (commit.ecode == ECODE_ADEF ||
                                   commit.ecode == ECODE_ALE  ||
                                   commit.ecode == ECODE_TLBR);

    ////////////////////////////////////////////////////////////////////
    // crmd / prmd
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b00;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b00;
            prmd_pie  <= 1'b0;
        end else if (exc_take) begin
            // save mode and drop to kernel with interrupts off
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            crmd_plv  <= 2'b00;
            crmd_ie   <= 1'b0;
        end else if (ertn_take) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // era / estat / badv
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            era_q          <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (exc_take) begin
            era_q          <= commit.pc;
            estat_ecode    <= commit.ecode;
            estat_esubcode <= commit.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badv_q <= '0;
        end else if (badv_take) begin
            badv_q <= commit.maddr;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////

    assign crmd  = {29'b0, crmd_ie, crmd_plv};
    assign prmd  = {29'b0, prmd_pie, prmd_pplv};
    assign era   = era_q;
    assign estat = {1'b0, estat_esubcode, estat_ecode, 16'b0};
    assign badv  = badv_q;

    assign csr_tid = CORE_ID;

    // ertn returns to the saved era and tlb refill has its own vector
    assign flush_pc = ertn_take   ? era_q     :
                      commit.tlbr ? TLBRENTRY :
                      EENTRY;

endmodule

//--- rtl/wb_top.sv
`timescale 1ns/1ps

module wb_top
    import exc_pkg::*;
    import wb_types_pkg::*;
#(
    parameter word_t EENTRY    = 32'h1C00_8000,
    parameter word_t TLBRENTRY = 32'h1C00_F000,
    parameter word_t CORE_ID   = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       in_valid,
    output logic       in_ready,
    input  wb_bundle_t in_bundle,

    output word_t      result_bypass,

    input  reg_idx_t   raddr1,
    output word_t      rdata1,
    input  reg_idx_t   raddr2,
    output word_t      rdata2,

    output logic       flush,
    output word_t      flush_pc,

    output word_t      crmd,
    output word_t      prmd,
    output word_t      era,
    output word_t      estat,
    output word_t      badv,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic        rf_we;
    reg_idx_t    rf_waddr;
    word_t       rf_wdata;
    commit_exc_t commit;
    word_t       csr_tid;

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_bundle         (in_bundle),
        .csr_tid           (csr_tid),
        .result_bypass     (result_bypass),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .commit            (commit),
        .flush             (flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2)
    );

    csr_exc_unit #(
        .EENTRY    (EENTRY),
        .TLBRENTRY (TLBRENTRY),
        .CORE_ID   (CORE_ID)
    ) u_csr_exc_unit (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .flush    (flush),
        .csr_tid  (csr_tid),
        .flush_pc (flush_pc),
        .crmd     (crmd),
        .prmd     (prmd),
        .era      (era),
        .estat    (estat),
        .badv     (badv)
    );

endmodule

//--- verification/wb_chk.sv
`timescale 1ns/1ps

module wb_chk
    import exc_pkg::*;
    import wb_types_pkg::*;
#(
    parameter word_t TLBRENTRY = 32'h1C00_F000
) (
    input logic        clk,
    input logic        reset,
    input logic        in_ready,
    input logic        flush,
    input word_t       flush_pc,
    input logic [3:0]  debug_wb_rf_we,
    input commit_exc_t commit
);

    // outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        reset |=> (!in_ready && !flush && debug_wb_rf_we == 4'b0))
        else $error("in_ready, flush or write enable high during reset");

    // an excepting instruction never retires a register write
    no_write_on_exc: assert property (@(posedge clk)
        (flush && commit.exception) |-> debug_wb_rf_we == 4'b0)
        else $error("register write in an exception flush cycle");

    tlbr_vector: assert property (@(posedge clk)
        (flush && commit.tlbr) |-> flush_pc == TLBRENTRY)
        else $error("tlb refill flush not sent to the refill entry");

    // the squashed beat leaves the slot empty
    idle_after_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> debug_wb_rf_we == 4'b0)
        else $error("register write in the cycle after a flush");

endmodule

bind wb_top wb_chk #(.TLBRENTRY(TLBRENTRY)) chk_i (
    .clk            (clk),
    .reset          (reset),
    .in_ready       (in_ready),
    .flush          (flush),
    .flush_pc       (flush_pc),
    .debug_wb_rf_we (debug_wb_rf_we),
    .commit         (commit)
);

//--- verification/wb_tb.sv
`timescale 1ns/1ps

module wb_tb
    import exc_pkg::*;
    import wb_types_pkg::*;
();

    localparam word_t EENTRY         = 32'h1C00_8000;
    localparam word_t TLBRENTRY      = 32'h1C00_F000;
    localparam word_t CORE_ID        = 32'h0000_0039;
    localparam int    TIMEOUT_CYCLES = 6000;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    wb_bundle_t in_bundle;
    reg_idx_t   raddr1;
    reg_idx_t   raddr2;
    word_t      rdata1;
    word_t      rdata2;
    word_t      result_bypass;
    logic       flush;
    word_t      flush_pc;
    word_t      crmd;
    word_t      prmd;
    word_t      era;
    word_t      estat;
    word_t      badv;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    // reference model state
    word_t      shadow_rf [32];
    word_t      exp_crmd;
    word_t      exp_prmd;
    word_t      exp_era;
    word_t      exp_estat;
    word_t      exp_badv;
    logic       pend_valid;
    wb_bundle_t pend;
    int         cycles = 0;

    wb_top #(
        .EENTRY    (EENTRY),
        .TLBRENTRY (TLBRENTRY),
        .CORE_ID   (CORE_ID)
    ) dut_i (
        .clk (clk), .reset (reset),
        .in_valid (in_valid), .in_ready (in_ready), .in_bundle (in_bundle),
        .result_bypass (result_bypass),
        .raddr1 (raddr1), .rdata1 (rdata1), .raddr2 (raddr2), .rdata2 (rdata2),
        .flush (flush), .flush_pc (flush_pc),
        .crmd (crmd), .prmd (prmd), .era (era), .estat (estat), .badv (badv),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_we (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            fail_run("timeout, the run went past its cycle limit");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else fail_run($sformatf("Error at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    ////////////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////////////

    function automatic word_t load_value(input wb_bundle_t b);
        word_t sh;
        sh = b.mem_rdata >> (8 * b.alu_result[1:0]);
        if (b.mem_op[MEM_OP_LB])
            return {{24{sh[7]}}, sh[7:0]};
        if (b.mem_op[MEM_OP_LH])
            return {{16{sh[15]}}, sh[15:0]};
        if (b.mem_op[MEM_OP_LW])
            return b.mem_rdata;
        if (b.mem_op[MEM_OP_LBU])
            return {24'h0, sh[7:0]};
        if (b.mem_op[MEM_OP_LHU])
            return {16'h0, sh[15:0]};
        return '0;
    endfunction

    function automatic word_t expected_result(input wb_bundle_t b);
        if (b.rdcntid)
            return CORE_ID;
        if (b.res_from_mem)
            return load_value(b);
        if (b.res_from_csr)
            return b.csr_result;
        if (b.res_from_mul)
            return b.mul_result;
        if (b.res_from_div)
            return b.div_result;
        return b.alu_result;
    endfunction

    function automatic word_t expected_bypass(input wb_bundle_t b);
        if (b.res_from_mem)
            return load_value(b);
        return b.res_from_csr ? b.csr_result : b.alu_result;
    endfunction

    function automatic ecode_t pick_ecode();
        case ($urandom % 6)
            0:       return ECODE_ADEF;
            1:       return ECODE_ALE;
            2:       return ECODE_SYS;
            3:       return ECODE_BRK;
            4:       return ECODE_INE;
            default: return ECODE_TLBR;
        endcase
    endfunction

    function automatic wb_bundle_t random_bundle(input logic with_exc);
        wb_bundle_t b;
        int         kind;
        b              = '0;
        b.inst_valid   = ($urandom % 8) != 0;
        b.pc           = $urandom & 32'hFFFF_FFFC;
        b.alu_result   = $urandom;
        b.mem_rdata    = $urandom;
        b.csr_result   = $urandom;
        b.mul_result   = $urandom;
        b.div_result   = $urandom;
        b.res_from_mem = ($urandom % 3) == 0;
        b.res_from_csr = ($urandom % 3) == 0;
        b.res_from_mul = ($urandom % 3) == 0;
        b.res_from_div = ($urandom % 3) == 0;
        b.rdcntid      = ($urandom % 6) == 0;
        b.gr_we        = ($urandom % 4) != 0;
        b.dest         = 5'($urandom);
        kind           = int'($urandom % 5);
        b.mem_op       = 8'(1 << kind);
        // keep the address aligned to the access size
        if (kind == MEM_OP_LW)
            b.alu_result[1:0] = 2'b00;
        else if (kind == MEM_OP_LH || kind == MEM_OP_LHU)
            b.alu_result[0] = 1'b0;
        if (with_exc && ($urandom % 12) == 0) begin
            b.exc.has_exception = 1'b1;
            b.exc.ecode         = pick_ecode();
            b.exc.esubcode      = 9'($urandom);
            b.exc.maddr         = $urandom;
        end else if (with_exc && ($urandom % 24) == 0) begin
            b.exc.ertn = 1'b1;
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // checking and driving
    ////////////////////////////////////////////////////////////////////

    task automatic check_csrs();
        check_word("crmd", crmd, exp_crmd);
        check_word("prmd", prmd, exp_prmd);
        check_word("era", era, exp_era);
        check_word("estat", estat, exp_estat);
        check_word("badv", badv, exp_badv);
    endtask

    // the slot holds b this cycle
    task automatic check_commit(input wb_bundle_t b);
        logic  exp_we;
        logic  exp_fl;
        word_t exp_res;
        exp_we  = b.gr_we & b.inst_valid & ~b.exc.has_exception;
        exp_fl  = b.exc.has_exception | b.exc.ertn;
        exp_res = expected_result(b);
        check_word("debug_wb_pc", debug_wb_pc, b.pc);
        check_word("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'({4{exp_we}}));
        check_word("result_bypass", result_bypass, expected_bypass(b));
        check_word("flush", 32'(flush), 32'(exp_fl));
        check_word("in_ready", 32'(in_ready), 32'(!exp_fl));
        if (exp_we) begin
            check_word("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(b.dest));
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_res);
            if (b.dest != 5'd0)
                shadow_rf[b.dest] = exp_res;
        end
        if (b.exc.has_exception) begin
            check_word("flush_pc", flush_pc,
                       b.exc.ecode == ECODE_TLBR ? TLBRENTRY : EENTRY);
            exp_prmd  = exp_crmd;
            exp_crmd  = '0;
            exp_era   = b.pc;
            exp_estat = {1'b0, b.exc.esubcode, b.exc.ecode, 16'h0};
            if (b.exc.ecode inside {ECODE_ADEF, ECODE_ALE, ECODE_TLBR})
                exp_badv = b.exc.maddr;
        end else if (b.exc.ertn) begin
            check_word("flush_pc", flush_pc, exp_era);
            exp_crmd = exp_prmd;
        end
    endtask

    // called on a falling edge and returns on the next one
    task automatic step(input logic valid, input wb_bundle_t b);
        check_csrs();
        if (pend_valid) begin
            check_commit(pend);
        end else begin
            check_word("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'h0);
            check_word("flush", 32'(flush), 32'h0);
            check_word("in_ready", 32'(in_ready), 32'h1);
        end
        in_valid   = valid;
        in_bundle  = b;
        pend_valid = valid && in_ready;
        pend       = b;
        @(negedge clk);
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i += 2) begin
            raddr1 = 5'(i);
            raddr2 = 5'(i + 1);
            #1;
            check_word("rdata1", rdata1, shadow_rf[i]);
            check_word("rdata2", rdata2, shadow_rf[i + 1]);
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_loads();
        wb_bundle_t b;
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                if (k == MEM_OP_LW && off != 0)
                    continue;
                if ((k == MEM_OP_LH || k == MEM_OP_LHU) && off[0])
                    continue;
                b                 = random_bundle(1'b0);
                b.inst_valid      = 1'b1;
                b.gr_we           = 1'b1;
                b.rdcntid         = 1'b0;
                b.res_from_mem    = 1'b1;
                b.mem_op          = 8'(1 << k);
                b.alu_result[1:0] = 2'(off);
                b.dest            = 5'(k * 4 + off + 1);
                step(1'b1, b);
            end
        end
        step(1'b0, '0);
        check_regs();
    endtask

    task automatic test_priority();
        wb_bundle_t b;
        for (int n = 0; n < 40; n++) begin
            b            = random_bundle(1'b0);
            b.inst_valid = 1'b1;
            b.gr_we      = 1'b1;
            step(1'b1, b);
        end
        step(1'b0, '0);
        check_regs();
    endtask

    task automatic test_gating();
        wb_bundle_t b;
        b            = random_bundle(1'b0);
        b.inst_valid = 1'b1;
        b.gr_we      = 1'b0;
        b.dest       = 5'd7;
        step(1'b1, b);
        b.gr_we      = 1'b1;
        b.inst_valid = 1'b0;
        step(1'b1, b);
        b.inst_valid = 1'b1;
        b.dest       = 5'd0;
        step(1'b1, b);
        step(1'b0, '0);
        check_regs();
    endtask

    // an exception beat and then a beat that the flush squashes
    task automatic send_exception(input ecode_t code);
        wb_bundle_t b;
        b                   = random_bundle(1'b0);
        b.inst_valid        = 1'b1;
        b.gr_we             = 1'b1;
        b.exc.has_exception = 1'b1;
        b.exc.ecode         = code;
        b.exc.esubcode      = 9'($urandom);
        b.exc.maddr         = $urandom;
        step(1'b1, b);
        step(1'b1, random_bundle(1'b0));
        step(1'b0, '0);
    endtask

    task automatic test_exceptions();
        send_exception(ECODE_ALE);
        send_exception(ECODE_SYS);
        send_exception(ECODE_TLBR);
        check_regs();
    endtask

    task automatic test_ertn();
        wb_bundle_t b;
        send_exception(ECODE_SYS);
        b          = random_bundle(1'b0);
        b.gr_we    = 1'b0;
        b.exc.ertn = 1'b1;
        step(1'b1, b);
        step(1'b0, '0);
        step(1'b0, '0);
    endtask

    task automatic test_stream();
        int sent;
        sent = 0;
        while (sent < 400) begin
            if (($urandom % 8) == 0) begin
                step(1'b0, '0);
            end else begin
                step(1'b1, random_bundle(1'b1));
                sent++;
            end
        end
        step(1'b0, '0);
        step(1'b0, '0);
        check_regs();
    endtask

    initial begin
        void'($urandom(57));
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_bundle  = '0;
        raddr1     = '0;
        raddr2     = '0;
        pend_valid = 1'b0;
        pend       = '0;
        exp_crmd   = '0;
        exp_prmd   = '0;
        exp_era    = '0;
        exp_estat  = '0;
        exp_badv   = '0;
        for (int i = 0; i < 32; i++)
            shadow_rf[i] = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_loads();
        test_priority();
        test_gating();
        test_exceptions();
        test_ertn();
        test_stream();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- flist.f
rtl/exc_pkg.sv
rtl/wb_types_pkg.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/csr_exc_unit.sv
rtl/wb_top.sv
verification/wb_chk.sv
verification/wb_tb.sv

//--- run.sh
#!/bin/sh
# build the writeback testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 -f flist.f --top-module wb_tb \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vwb_tb > sim.log 2>&1
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
